// ==== common/rms_pkg.sv ====
`default_nettype none

package rms_pkg;

	//////////////////////////////
	// Data path widths
	//////////////////////////////

	// Input sample, as held in the old sample memory
	localparam int SAMPLE_W = 29;
	// Full product of a sample with itself
	localparam int SQUARE_W = 2 * SAMPLE_W;
	// Block sum and divider dividend
	localparam int SUM_W = 64;
	// Result word on the output stream
	localparam int RESULT_W = 32;

	//////////////////////////////
	// Divider and display
	//////////////////////////////

	// One quotient bit per step
	localparam int DIV_STEPS = SUM_W;
	// Six seven-segment digits
	localparam int DIGITS = 6;
	localparam int SEG_W = 7;
	// Alternating 1 and A, digit 0 shows 1
	localparam logic [4*DIGITS-1:0] RESET_DISPLAY = 24'hA1A1A1;

endpackage

`default_nettype wire

// ==== src/hex_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module hex_display import rms_pkg::*;
(
	input  logic                CLOCK_50,
	input  logic                reset,
	input  logic                load,
	input  logic [RESULT_W-1:0] value,
	output logic [SEG_W-1:0]    hex0,
	output logic [SEG_W-1:0]    hex1,
	output logic [SEG_W-1:0]    hex2,
	output logic [SEG_W-1:0]    hex3,
	output logic [SEG_W-1:0]    hex4,
	output logic [SEG_W-1:0]    hex5
);

	// One nibble per digit, digit 0 in the low bits
	logic [4*DIGITS-1:0] shown;
	logic [SEG_W-1:0]    seg [DIGITS];

	// Hex digit to segments, active low, bit 0 is a and bit 6 is g
	function automatic logic [SEG_W-1:0] seg_decode(input logic [3:0] nibble);
		case (nibble)
			4'h0: seg_decode = 7'b1000000;
			4'h1: seg_decode = 7'b1111001;
			4'h2: seg_decode = 7'b0100100;
			4'h3: seg_decode = 7'b0110000;
			4'h4: seg_decode = 7'b0011001;
			4'h5: seg_decode = 7'b0010010;
			4'h6: seg_decode = 7'b0000010;
			4'h7: seg_decode = 7'b1111000;
			4'h8: seg_decode = 7'b0000000;
			4'h9: seg_decode = 7'b0010000;
			4'hA: seg_decode = 7'b0001000;
			4'hB: seg_decode = 7'b0000011;
			4'hC: seg_decode = 7'b1000110;
			4'hD: seg_decode = 7'b0100001;
			4'hE: seg_decode = 7'b0000110;
			default: seg_decode = 7'b0001110;
		endcase
	endfunction

	// Last accepted mean, 1A pattern out of reset
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
			shown <= RESET_DISPLAY;
		else if (load)
			shown <= value[4*DIGITS-1:0];
	end

	for (genvar g = 0; g < DIGITS; g++)
	begin : g_digit
		assign seg[g] = seg_decode(shown[4*g +: 4]);
	end

	assign hex0 = seg[0];
	assign hex1 = seg[1];
	assign hex2 = seg[2];
	assign hex3 = seg[3];
	assign hex4 = seg[4];
	assign hex5 = seg[5];

endmodule

`default_nettype wire

// ==== square_accumulator/square_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module square_accumulator import rms_pkg::*;
#(
	parameter int BLOCK_LEN = 20480
)
(
	input  logic                CLOCK_50,
	input  logic                reset,
	input  logic [SAMPLE_W-1:0] in_data,
	input  logic                in_valid,
	output logic                in_ready,
	output logic [SUM_W-1:0]    block_sum,
	output logic                sum_valid,
	input  logic                sum_ready
);

	// Samples taken so far in this block
	logic [$clog2(BLOCK_LEN+1)-1:0] count;
	logic                           accept;
	logic                           full;

	// Stage one holds the sample and its last flag
	logic [SAMPLE_W-1:0] s1_data;
	logic                s1_valid;
	logic                s1_last;

	// Stage two adds the square into the running sum
	logic [SQUARE_W-1:0] square;
	logic [SUM_W-1:0]    acc;
	logic [SUM_W-1:0]    sum_next;

	assign accept = in_valid & in_ready;
	// Count sits at BLOCK_LEN only while the last sample is in stage one
	assign full = (int'(count) == BLOCK_LEN);
	// No intake between the last sample and the sum hand-off
	assign in_ready = ~full & ~sum_valid;

	assign square = SQUARE_W'(s1_data) * SQUARE_W'(s1_data);
	// Wraps modulo 2^64
	assign sum_next = acc + SUM_W'(square);

	//////////////////////////////
	// Block control
	//////////////////////////////
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			count <= '0;
			s1_valid <= 1'b0;
			s1_last <= 1'b0;
			acc <= '0;
			sum_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= accept;
			s1_last <= accept && (int'(count) == BLOCK_LEN - 1);

			// Count clears as the last square lands
			if (s1_valid && s1_last)
				count <= '0;
			else if (accept)
				count <= count + 1'b1;

			// Running sum, restarted for the next block
			if (s1_valid)
			begin
				if (s1_last)
					acc <= '0;
				else
					acc <= sum_next;
			end

			// Finished sum waits here for the divider
			if (sum_valid && sum_ready)
				sum_valid <= 1'b0;
			else if (s1_valid && s1_last)
				sum_valid <= 1'b1;
		end
	end

	//////////////////////////////
	// Payload registers
	//////////////////////////////
	always_ff @(posedge CLOCK_50)
	begin
		if (accept)
			s1_data <= in_data;
		// Sum including the final square of the block
		if (s1_valid && s1_last)
			block_sum <= sum_next;
	end

endmodule

`default_nettype wire

// ==== mean_divider/mean_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module mean_divider import rms_pkg::*;
#(
	parameter int BLOCK_LEN = 20480
)
(
	input  logic                CLOCK_50,
	input  logic                reset,
	input  logic [SUM_W-1:0]    block_sum,
	input  logic                sum_valid,
	output logic                sum_ready,
	output logic [RESULT_W-1:0] out_data,
	output logic                out_valid,
	input  logic                out_ready
);

	// Divider running its steps
	logic                         busy;
	logic [$clog2(DIV_STEPS)-1:0] step;
	logic                         last_step;
	logic                         take_sum;

	// Partial remainder, always below BLOCK_LEN between steps
	logic [SUM_W-1:0] rem;
	// Dividend shifts out the top, quotient bits shift in below
	logic [SUM_W-1:0] quot;

	// One restoring step
	logic [SUM_W:0]   trial;
	logic             fits;
	logic [SUM_W-1:0] diff;
	logic [SUM_W-1:0] rem_next;

	// Idle means neither dividing nor holding a result
	assign sum_ready = ~busy & ~out_valid;
	assign take_sum = sum_valid & sum_ready;
	assign last_step = (int'(step) == DIV_STEPS - 1);

	// Bring down the next dividend bit
	assign trial = {rem, quot[SUM_W-1]};
	assign fits = (trial >= (SUM_W+1)'(BLOCK_LEN));
	// Modulo arithmetic is exact here since the result is below BLOCK_LEN
	assign diff = trial[SUM_W-1:0] - SUM_W'(BLOCK_LEN);
	assign rem_next = fits ? diff : trial[SUM_W-1:0];

	// Low bits of the mean, truncated to the FIFO word
	assign out_data = quot[RESULT_W-1:0];

	//////////////////////////////
	// Sequencing
	//////////////////////////////
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			out_valid <= 1'b0;
			step <= '0;
		end
		else
		begin
			if (take_sum)
			begin
				busy <= 1'b1;
				step <= '0;
			end
			else if (busy)
			begin
				step <= step + 1'b1;
				// Quotient complete after DIV_STEPS bits
				if (last_step)
				begin
					busy <= 1'b0;
					out_valid <= 1'b1;
				end
			end
			else if (out_valid && out_ready)
			begin
				// Result taken, back to idle
				out_valid <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Remainder and quotient
	//////////////////////////////
	always_ff @(posedge CLOCK_50)
	begin
		if (take_sum)
		begin
			rem <= '0;
			quot <= block_sum;
		end
		else if (busy)
		begin
			rem <= rem_next;
			quot <= {quot[SUM_W-2:0], fits};
		end
		// Held while out_valid waits for out_ready
	end

endmodule

`default_nettype wire

// ==== src/rms_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rms_top import rms_pkg::*;
#(
	parameter int BLOCK_LEN = 20480
)
(
	input  logic                CLOCK_50,
	input  logic                reset,
	// Sample stream from the host
	input  logic [SAMPLE_W-1:0] in_data,
	input  logic                in_valid,
	output logic                in_ready,
	// Result stream to the host
	output logic [RESULT_W-1:0] out_data,
	output logic                out_valid,
	input  logic                out_ready,
	// Seven-segment digits, active low
	output logic [SEG_W-1:0]    hex0,
	output logic [SEG_W-1:0]    hex1,
	output logic [SEG_W-1:0]    hex2,
	output logic [SEG_W-1:0]    hex3,
	output logic [SEG_W-1:0]    hex4,
	output logic [SEG_W-1:0]    hex5
);

	// Finished block sum between accumulator and divider
	logic [SUM_W-1:0] block_sum;
	logic             sum_valid;
	logic             sum_ready;
	// Result transfer strobe for the display
	logic             result_taken;

	assign result_taken = out_valid & out_ready;

	//////////////////////////////
	// Square and accumulate
	//////////////////////////////
	square_accumulator #(
		.BLOCK_LEN (BLOCK_LEN)
	) u_square_accumulator (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.in_data   (in_data),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.block_sum (block_sum),
		.sum_valid (sum_valid),
		.sum_ready (sum_ready)
	);

	//////////////////////////////
	// Mean of the block
	//////////////////////////////
	mean_divider #(
		.BLOCK_LEN (BLOCK_LEN)
	) u_mean_divider (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.block_sum (block_sum),
		.sum_valid (sum_valid),
		.sum_ready (sum_ready),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	// Last accepted mean on the board digits
	hex_display u_hex_display (
		.CLOCK_50 (CLOCK_50),
		.reset    (reset),
		.load     (result_taken),
		.value    (out_data),
		.hex0     (hex0),
		.hex1     (hex1),
		.hex2     (hex2),
		.hex3     (hex3),
		.hex4     (hex4),
		.hex5     (hex5)
	);

endmodule

`default_nettype wire

// ==== tests/rms_top_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module rms_top_properties import rms_pkg::*;
(
	input  logic                CLOCK_50,
	input  logic                reset,
	input  logic                in_ready,
	input  logic                sum_valid,
	input  logic                sum_ready,
	input  logic [RESULT_W-1:0] out_data,
	input  logic                out_valid,
	input  logic                out_ready
);

	// Failures per rule
	int hold_fails = 0;
	int stable_fails = 0;
	int stall_fails = 0;
	int fail_count;

	assign fail_count = hold_fails + stable_fails + stall_fails;

	//////////////////////////////
	// Result stream
	//////////////////////////////

	// Result offered, not yet taken
	a_out_valid_held: assert property (@(posedge CLOCK_50) disable iff (reset)
		out_valid && !out_ready |=> out_valid)
	else
	begin
		$error("out_valid fell before the result was taken");
		hold_fails++;
	end

	a_out_data_stable: assert property (@(posedge CLOCK_50) disable iff (reset)
		out_valid && !out_ready |=> $stable(out_data))
	else
	begin
		$error("out_data changed while the result waited");
		stable_fails++;
	end

	//////////////////////////////
	// Sample intake
	//////////////////////////////

	// Finished sum stays parked for the divider, intake stays closed
	a_intake_stalled: assert property (@(posedge CLOCK_50) disable iff (reset)
		sum_valid && !sum_ready |=> sum_valid && !in_ready)
	else
	begin
		$error("finished sum lost or in_ready high while it waited");
		stall_fails++;
	end

endmodule

bind rms_top rms_top_properties u_properties (
	.CLOCK_50  (CLOCK_50),
	.reset     (reset),
	.in_ready  (in_ready),
	.sum_valid (sum_valid),
	.sum_ready (sum_ready),
	.out_data  (out_data),
	.out_valid (out_valid),
	.out_ready (out_ready)
);

`default_nettype wire

// ==== tests/rms_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rms_top_tb import rms_pkg::*;
();

	localparam int BLOCK_LEN = 5;
	// Blocks sent over the whole run
	localparam int NUM_BLOCKS = 7;
	localparam int CYCLE_LIMIT = NUM_BLOCKS * (BLOCK_LEN + DIV_STEPS + 20) * 2;

	logic                CLOCK_50;
	logic                reset;
	logic [SAMPLE_W-1:0] in_data;
	logic                in_valid;
	logic                in_ready;
	logic [RESULT_W-1:0] out_data;
	logic                out_valid;
	logic                out_ready;
	logic [SEG_W-1:0]    hex0;
	logic [SEG_W-1:0]    hex1;
	logic [SEG_W-1:0]    hex2;
	logic [SEG_W-1:0]    hex3;
	logic [SEG_W-1:0]    hex4;
	logic [SEG_W-1:0]    hex5;

	logic [31:0]         lfsr;
	// Reference means, oldest first
	logic [RESULT_W-1:0] expected_means [$];
	// Active low, bit 0 is segment a
	logic [SEG_W-1:0]    seg_table [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12,
		7'h02, 7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
	int cycle_count;
	int test_errors;
	int display_errors;
	int tests_run;
	int tests_failed;
	int total_errors;

	rms_top #(
		.BLOCK_LEN (BLOCK_LEN)
	) u_dut (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.in_data   (in_data),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.hex0      (hex0),
		.hex1      (hex1),
		.hex2      (hex2),
		.hex3      (hex3),
		.hex4      (hex4),
		.hex5      (hex5)
	);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #20 CLOCK_50 = ~CLOCK_50;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			bits = {bits[30:0], lfsr[0]};
		end
		return bits;
	endfunction

	// Drive point, just after the rising edge
	task automatic next_cycle();
		@(posedge CLOCK_50);
		#2;
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual == expected)
		else
		begin
			$display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			test_errors++;
		end
	endtask

	// hex0 carries the low nibble
	task automatic check_display(input string name, input logic [23:0] word,
		input bit after_result);
		logic [SEG_W-1:0] digits [DIGITS];
		digits = '{hex0, hex1, hex2, hex3, hex4, hex5};
		for (int d = 0; d < DIGITS; d++)
		begin
			assert (digits[d] == seg_table[word[4*d +: 4]])
			else
			begin
				$display("[ERROR] %s hex%0d: expected 0x%0h, actual 0x%0h",
					name, d, seg_table[word[4*d +: 4]], digits[d]);
				if (after_result)
					display_errors++;
				else
					test_errors++;
			end
		end
	endtask

	// One block of 12-bit samples, optional idle gaps before each
	task automatic send_block(input bit with_gaps);
		logic [SAMPLE_W-1:0] sample;
		logic [63:0]         sum;
		bit                  taken;
		sum = '0;
		for (int i = 0; i < BLOCK_LEN; i++)
		begin
			sample = SAMPLE_W'(random_bits(12));
			if (with_gaps)
			begin
				in_valid = 1'b0;
				repeat (1 + int'(random_bits(2))) next_cycle();
			end
			in_data = sample;
			in_valid = 1'b1;
			taken = 1'b0;
			while (!taken)
			begin
				@(negedge CLOCK_50);
				taken = in_ready;
				next_cycle();
			end
			sum = sum + 64'(sample) * 64'(sample);
		end
		in_valid = 1'b0;
		// Floor of the mean square, low 32 bits
		expected_means.push_back(RESULT_W'(sum / 64'(BLOCK_LEN)));
	endtask

	task automatic receive_result(input string name);
		logic [RESULT_W-1:0] expected;
		bit                  taken;
		expected = expected_means.pop_front();
		out_ready = 1'b1;
		taken = 1'b0;
		while (!taken)
		begin
			@(negedge CLOCK_50);
			taken = out_valid;
			if (taken)
				check_value(name, 64'(expected), 64'(out_data));
			next_cycle();
		end
		// Display took the word on the transfer edge
		@(negedge CLOCK_50);
		check_display("display_digits", expected[23:0], 1'b1);
		next_cycle();
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		total_errors += test_errors;
		if (test_errors == 0)
			$display("test %s: passed", name);
		else
		begin
			$display("test %s: failed with %0d errors", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////
	initial
	begin
		logic [RESULT_W-1:0] held;
		int                  prop_failures;
		reset = 1'b1;
		in_data = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		lfsr = 32'h5a8d0000;
		test_errors = 0;
		display_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		total_errors = 0;
		repeat (2) @(posedge CLOCK_50);
		#2;
		reset = 1'b0;

		// Idle outputs and the 1A pattern
		@(negedge CLOCK_50);
		check_value("reset_state out_valid", 64'd0, 64'(out_valid));
		check_value("reset_state in_ready", 64'd1, 64'(in_ready));
		check_display("reset_state", 24'hA1A1A1, 1'b0);
		next_cycle();
		finish_test("reset_state");

		out_ready = 1'b1;
		send_block(1'b0);
		receive_result("single_block");
		finish_test("single_block");

		// Each mean from its own block only
		for (int b = 0; b < 3; b++)
		begin
			send_block(1'b0);
			receive_result("consecutive_blocks");
		end
		finish_test("consecutive_blocks");

		// Second block parks its sum behind the held result
		out_ready = 1'b0;
		send_block(1'b0);
		held = expected_means[0];
		send_block(1'b0);
		@(negedge CLOCK_50);
		while (!out_valid)
			@(negedge CLOCK_50);
		repeat (4 + int'(random_bits(4)))
		begin
			check_value("backpressure out_valid", 64'd1, 64'(out_valid));
			check_value("backpressure out_data", 64'(held), 64'(out_data));
			check_value("backpressure in_ready", 64'd0, 64'(in_ready));
			@(negedge CLOCK_50);
		end
		next_cycle();
		receive_result("backpressure");
		receive_result("backpressure");
		finish_test("backpressure");

		send_block(1'b1);
		receive_result("valid_gaps");
		finish_test("valid_gaps");

		// Digits checked after every accepted result
		test_errors = display_errors;
		finish_test("display_digits");

		prop_failures = u_dut.u_properties.fail_count;
		if (prop_failures != 0)
			$display("Concurrent assertions failed %0d times", prop_failures);
		total_errors += prop_failures;
		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, total_errors);
		if (total_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// Run limit from the block count
	initial
	begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT)
		begin
			@(posedge CLOCK_50);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rms_top.f ====
common/rms_pkg.sv
src/hex_display.sv
square_accumulator/square_accumulator.sv
mean_divider/mean_divider.sv
src/rms_top.sv
tests/rms_top_properties.sv
tests/rms_top_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := rms_top_tb
FILELIST   := rms_top.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall
# Keep running past $error so the testbench prints its summary
RUN_FLAGS  := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
